// ==== arcade_pkg.sv ====
// Shared constants for the arcade platform shell.
// Widths, keyboard scan codes, joystick and core button bit positions,
// status word bit indices and scanline modes. Referenced by scoped name.

package arcade_pkg;

	// Widths
	localparam int color_in_w  = 3;
	localparam int color_out_w = 6;
	localparam int audio_w     = 10;
	localparam int key_code_w  = 8;

	// Keyboard scan codes
	localparam logic [key_code_w-1:0] key_up     = 8'h75;
	localparam logic [key_code_w-1:0] key_down   = 8'h72;
	localparam logic [key_code_w-1:0] key_left   = 8'h6B;
	localparam logic [key_code_w-1:0] key_right  = 8'h74;
	localparam logic [key_code_w-1:0] key_coin   = 8'h76; // ESC
	localparam logic [key_code_w-1:0] key_start1 = 8'h05; // F1
	localparam logic [key_code_w-1:0] key_start2 = 8'h06; // F2
	localparam logic [key_code_w-1:0] key_fire1  = 8'h29; // Space
	localparam logic [key_code_w-1:0] key_fire2  = 8'h11; // Alt
	localparam logic [key_code_w-1:0] key_fire3  = 8'h14; // Ctrl

	// Joystick word bits
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire1 = 4;
	localparam int joy_fire2 = 5;

	// Core button word bits, active low at the core
	localparam int btn_up     = 0;
	localparam int btn_down   = 1;
	localparam int btn_left   = 2;
	localparam int btn_right  = 3;
	localparam int btn_start1 = 4;
	localparam int btn_coin   = 5;
	localparam int btn_fire   = 6;
	localparam int btn_start2 = 7;

	// Status word bits from the OSD menu
	localparam int st_reset      = 0;
	localparam int st_rotate     = 2;
	localparam int st_scan_lo    = 3;
	localparam int st_scan_hi    = 4;
	localparam int st_soft_reset = 6;

	// Scanline modes, in status bit order
	localparam logic [1:0] scan_off = 2'd0;
	localparam logic [1:0] scan_25  = 2'd1;
	localparam logic [1:0] scan_50  = 2'd2;
	localparam logic [1:0] scan_75  = 2'd3;

endpackage

// ==== kbd_buttons_if.sv ====
// Held keyboard button levels, from the scan-code decoder to the
// control mapper. All signals are plain levels in the clk_sys domain.

`timescale 1ns/1ps

interface kbd_buttons_if;

	logic up;
	logic down;
	logic left;
	logic right;
	logic coin;
	logic start1;
	logic start2;
	logic fire1;
	logic fire2;
	logic fire3; // Decoded, not used by the core

	modport source (
		output up, down, left, right, coin,
		output start1, start2, fire1, fire2, fire3
	);

	modport sink (
		input up, down, left, right, coin,
		input start1, start2, fire1, fire2, fire3
	);

endinterface

// ==== clock_enables.sv ====
// Clock enable generator for the game core.
// Registers run on the falling edge so the enables are settled at the
// rising edge where the core samples them. ce_star is every second cycle,
// ce_6p one in four, ce_1p79 one in AUDIO_DIV.

`timescale 1ns/1ps

module clock_enables #(
	parameter int AUDIO_DIV = 14
) (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_star,
	output logic ce_6p,
	output logic ce_1p79
);

	localparam int DIV_W = (AUDIO_DIV > 1) ? $clog2(AUDIO_DIV) : 1;

	logic [1:0]       pix_div;  // Free running
	logic [DIV_W-1:0] snd_cnt;  // Sound down-counter

	always_ff @(negedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pix_div <= '0;
			snd_cnt <= '0;
			ce_star <= 1'b0;
			ce_6p   <= 1'b0;
			ce_1p79 <= 1'b0;
		end else begin
			pix_div <= pix_div + 2'd1;
			ce_star <= pix_div[0];
			ce_6p   <= pix_div[0] & ~pix_div[1]; // Subset of ce_star

			if (snd_cnt == '0) begin
				snd_cnt <= DIV_W'(AUDIO_DIV - 1);
				ce_1p79 <= 1'b1;
			end else begin
				snd_cnt <= snd_cnt - 1'b1;
				ce_1p79 <= 1'b0;
			end
		end
	end

endmodule

// ==== key_decoder.sv ====
// Keyboard event decoder.
// Each key_strobe carries one scan code with its pressed flag. The
// matching button register takes the flag and holds it until the release
// event for that key arrives. Unknown codes are ignored.

`timescale 1ns/1ps

module key_decoder (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            key_strobe,
	input  logic                            key_pressed,
	input  logic [arcade_pkg::key_code_w-1:0] key_code,
	kbd_buttons_if.source                   kbd
);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			kbd.up     <= 1'b0;
			kbd.down   <= 1'b0;
			kbd.left   <= 1'b0;
			kbd.right  <= 1'b0;
			kbd.coin   <= 1'b0;
			kbd.start1 <= 1'b0;
			kbd.start2 <= 1'b0;
			kbd.fire1  <= 1'b0;
			kbd.fire2  <= 1'b0;
			kbd.fire3  <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				arcade_pkg::key_up:     kbd.up     <= key_pressed;
				arcade_pkg::key_down:   kbd.down   <= key_pressed;
				arcade_pkg::key_left:   kbd.left   <= key_pressed;
				arcade_pkg::key_right:  kbd.right  <= key_pressed;
				arcade_pkg::key_coin:   kbd.coin   <= key_pressed;
				arcade_pkg::key_start1: kbd.start1 <= key_pressed;
				arcade_pkg::key_start2: kbd.start2 <= key_pressed;
				arcade_pkg::key_fire1:  kbd.fire1  <= key_pressed;
				arcade_pkg::key_fire2:  kbd.fire2  <= key_pressed;
				arcade_pkg::key_fire3:  kbd.fire3  <= key_pressed;
				default: ; // Keys the game does not use
			endcase
		end
	end

endmodule

// ==== control_mapper.sv ====
// Merges keyboard and both joysticks into the core button word.
// Rotation is active while status rotate bit is clear, matching a
// vertical monitor turned on its side. Also combines the reset sources.
// Both outputs are registered, one cycle after the inputs.

`timescale 1ns/1ps

module control_mapper (
	input  logic        clk_sys,
	input  logic        rst_n,
	kbd_buttons_if.sink kbd,
	input  logic [7:0]  joystick_0,
	input  logic [7:0]  joystick_1,
	input  logic [31:0] status,
	input  logic [1:0]  buttons,
	output logic [7:0]  core_buttons_n,
	output logic        core_reset
);

	logic in_up, in_down, in_left, in_right; // Merged, before rotation
	logic rotate;
	logic [7:0] btn_word;                    // Active high

	assign in_up    = kbd.up    | joystick_0[arcade_pkg::joy_up]    | joystick_1[arcade_pkg::joy_up];
	assign in_down  = kbd.down  | joystick_0[arcade_pkg::joy_down]  | joystick_1[arcade_pkg::joy_down];
	assign in_left  = kbd.left  | joystick_0[arcade_pkg::joy_left]  | joystick_1[arcade_pkg::joy_left];
	assign in_right = kbd.right | joystick_0[arcade_pkg::joy_right] | joystick_1[arcade_pkg::joy_right];

	assign rotate = ~status[arcade_pkg::st_rotate];

	always_comb begin
		btn_word = '0;
		btn_word[arcade_pkg::btn_up]     = rotate ? in_left  : in_up;
		btn_word[arcade_pkg::btn_down]   = rotate ? in_right : in_down;
		btn_word[arcade_pkg::btn_left]   = rotate ? in_down  : in_left;
		btn_word[arcade_pkg::btn_right]  = rotate ? in_up    : in_right;
		btn_word[arcade_pkg::btn_start1] = kbd.start1;
		btn_word[arcade_pkg::btn_coin]   = kbd.coin;
		btn_word[arcade_pkg::btn_fire]   = kbd.fire1 | joystick_0[arcade_pkg::joy_fire1]
			| joystick_1[arcade_pkg::joy_fire1];
		btn_word[arcade_pkg::btn_start2] = kbd.start2;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			core_buttons_n <= '1; // Nothing pressed
			core_reset     <= 1'b1;
		end else begin
			core_buttons_n <= ~btn_word;
			core_reset     <= status[arcade_pkg::st_reset] | status[arcade_pkg::st_soft_reset]
				| buttons[1];
		end
	end

endmodule

// ==== video_output.sv ====
// VGA output stage for the 3-bit core colour.
// Blanked pixels are forced to black, the rest widened to six bits by bit
// repetition. On odd lines the chosen scanline mode darkens the pixel.
// Syncs come out inverted. Everything is one register stage deep.

`timescale 1ns/1ps

module video_output (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic [arcade_pkg::color_in_w-1:0]  core_r,
	input  logic [arcade_pkg::color_in_w-1:0]  core_g,
	input  logic [arcade_pkg::color_in_w-1:0]  core_b,
	input  logic                             core_hs,
	input  logic                             core_vs,
	input  logic                             core_hblank,
	input  logic                             core_vblank,
	input  logic [31:0]                      status,
	output logic [arcade_pkg::color_out_w-1:0] vga_r,
	output logic [arcade_pkg::color_out_w-1:0] vga_g,
	output logic [arcade_pkg::color_out_w-1:0] vga_b,
	output logic                             vga_hs,
	output logic                             vga_vs
);

	logic       hs_d;      // Previous core_hs
	logic       line_odd;
	logic       blank;
	logic [1:0] scan_mode;

	// Expand one channel and apply scanline dimming
	function automatic logic [arcade_pkg::color_out_w-1:0] shade(
		input logic [arcade_pkg::color_in_w-1:0] c,
		input logic                              dim,
		input logic [1:0]                        mode
	);
		logic [arcade_pkg::color_out_w-1:0] full;
		full = {c, c};
		if (!dim)
			return full;
		case (mode)
			arcade_pkg::scan_25: return full - (full >> 2);
			arcade_pkg::scan_50: return full >> 1;
			arcade_pkg::scan_75: return full >> 2;
			default:             return full; // scan_off
		endcase
	endfunction

	assign blank     = core_hblank | core_vblank;
	assign scan_mode = {status[arcade_pkg::st_scan_hi], status[arcade_pkg::st_scan_lo]};

	// ==================================================================
	// Line parity and pixel register
	// ==================================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hs_d     <= 1'b0;
			line_odd <= 1'b0;
			vga_r    <= '0;
			vga_g    <= '0;
			vga_b    <= '0;
			vga_hs   <= 1'b1;
			vga_vs   <= 1'b1;
		end else begin
			hs_d <= core_hs;
			if (core_hs && !hs_d)
				line_odd <= ~line_odd; // New line
			vga_r  <= blank ? '0 : shade(core_r, line_odd, scan_mode);
			vga_g  <= blank ? '0 : shade(core_g, line_odd, scan_mode);
			vga_b  <= blank ? '0 : shade(core_b, line_odd, scan_mode);
			vga_hs <= ~core_hs;
			vga_vs <= ~core_vs;
		end
	end

endmodule

// ==== sigma_delta_dac.sv ====
// First-order sigma-delta DAC with a one-bit output.
// The sample is added into an accumulator one bit wider than the input
// every cycle; the carry out is the output bit. For a constant input v
// the output is high on v cycles of every 2**DAC_WIDTH.

`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int DAC_WIDTH = arcade_pkg::audio_w
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic [DAC_WIDTH-1:0] dac_in,
	output logic                 dac_out
);

	logic [DAC_WIDTH:0] acc;     // MSB holds the last carry
	logic [DAC_WIDTH:0] acc_nxt;

	// Carry from the previous sum is dropped before adding again
	assign acc_nxt = {1'b0, acc[DAC_WIDTH-1:0]} + {1'b0, dac_in};

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= acc_nxt;
	end

	assign dac_out = acc[DAC_WIDTH]; // Straight from the flop

endmodule

// ==== arcade_shell.sv ====
// Platform shell around an external arcade game core.
// Generates the core clock enables, maps keyboard and joysticks onto the
// core buttons, combines resets, drives VGA and the audio DAC.
// All signals are plain ports; the game core connects to the core_* pins.

`timescale 1ns/1ps

module arcade_shell #(
	parameter int AUDIO_DIV = 14,
	parameter int DAC_WIDTH = arcade_pkg::audio_w
) (
	input  logic                               clk_sys,
	input  logic                               rst_n,
	// Core clock enables
	output logic                               ce_star,
	output logic                               ce_6p,
	output logic                               ce_1p79,
	// Keyboard events and menu state
	input  logic                               key_strobe,
	input  logic                               key_pressed,
	input  logic [arcade_pkg::key_code_w-1:0]  key_code,
	input  logic [7:0]                         joystick_0,
	input  logic [7:0]                         joystick_1,
	input  logic [31:0]                        status,
	input  logic [1:0]                         buttons,
	// Core controls
	output logic [7:0]                         core_buttons_n,
	output logic                               core_reset,
	// Core video and audio
	input  logic [arcade_pkg::color_in_w-1:0]  core_r,
	input  logic [arcade_pkg::color_in_w-1:0]  core_g,
	input  logic [arcade_pkg::color_in_w-1:0]  core_b,
	input  logic                               core_hs,
	input  logic                               core_vs,
	input  logic                               core_hblank,
	input  logic                               core_vblank,
	input  logic [DAC_WIDTH-1:0]               core_audio,
	// Board outputs
	output logic [arcade_pkg::color_out_w-1:0] vga_r,
	output logic [arcade_pkg::color_out_w-1:0] vga_g,
	output logic [arcade_pkg::color_out_w-1:0] vga_b,
	output logic                               vga_hs,
	output logic                               vga_vs,
	output logic                               audio_l,
	output logic                               audio_r
);

	kbd_buttons_if kbd_bus ();

	clock_enables #(.AUDIO_DIV(AUDIO_DIV)) u_clock_enables (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_star (ce_star),
		.ce_6p   (ce_6p),
		.ce_1p79 (ce_1p79)
	);

	key_decoder u_key_decoder (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.kbd         (kbd_bus)
	);

	control_mapper u_control_mapper (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.kbd            (kbd_bus),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.status         (status),
		.buttons        (buttons),
		.core_buttons_n (core_buttons_n),
		.core_reset     (core_reset)
	);

	video_output u_video_output (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.core_r      (core_r),
		.core_g      (core_g),
		.core_b      (core_b),
		.core_hs     (core_hs),
		.core_vs     (core_vs),
		.core_hblank (core_hblank),
		.core_vblank (core_vblank),
		.status      (status),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs)
	);

	sigma_delta_dac #(.DAC_WIDTH(DAC_WIDTH)) u_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.dac_in  (core_audio),
		.dac_out (audio_l)
	);

	assign audio_r = audio_l; // Mono core

endmodule

// ==== arcade_shell_assertions.sv ====
// Concurrent checks on the arcade shell top level, attached by bind.
// Covers the clock enable relations and the core button word in reset.

`timescale 1ns/1ps

module arcade_shell_assertions (
	input logic       clk_sys,
	input logic       rst_n,
	input logic       ce_star,
	input logic       ce_6p,
	input logic       ce_1p79,
	input logic [7:0] core_buttons_n
);

	// Enables settle on the falling edge, so the rising edge sees them stable
	ce_6p_in_star: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_6p |-> ce_star)
		else $error("ce_6p high without ce_star");

	ce_1p79_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_1p79 |=> !ce_1p79)
		else $error("ce_1p79 high on two cycles in a row");

	buttons_idle_in_reset: assert property (@(posedge clk_sys)
		!rst_n |-> core_buttons_n == 8'hFF)
		else $error("core_buttons_n not all ones during reset");

endmodule

bind arcade_shell arcade_shell_assertions u_assertions (
	.clk_sys        (clk_sys),
	.rst_n          (rst_n),
	.ce_star        (ce_star),
	.ce_6p          (ce_6p),
	.ce_1p79        (ce_1p79),
	.core_buttons_n (core_buttons_n)
);

// ==== tb_arcade_shell.sv ====
// Testbench for the arcade platform shell.
// Random stimulus from a fixed seed is driven on the falling clock edge.
// Each result is compared with a model kept in this file. One line is
// printed per test, then the counts and the overall result.

`timescale 1ns/1ps

module tb_arcade_shell;

	localparam int AUDIO_DIV = 14;
	localparam int DAC_WIDTH = arcade_pkg::audio_w;
	localparam int CW        = arcade_pkg::color_out_w;

	logic                              clk_sys, rst_n, ce_star, ce_6p, ce_1p79;
	logic                              key_strobe, key_pressed, core_reset;
	logic [7:0]                        key_code, joystick_0, joystick_1, core_buttons_n;
	logic [31:0]                       status;
	logic [1:0]                        buttons;
	logic [arcade_pkg::color_in_w-1:0] core_r, core_g, core_b;
	logic                              core_hs, core_vs, core_hblank, core_vblank;
	logic [DAC_WIDTH-1:0]              core_audio;
	logic [CW-1:0]                     vga_r, vga_g, vga_b;
	logic                              vga_hs, vga_vs, audio_l, audio_r;

	integer seed;
	int     errors;
	int     checks;
	logic   kbd_model [10]; // up down left right coin start1 start2 fire1 fire2 fire3
	logic [7:0] key_table [10] = '{arcade_pkg::key_up, arcade_pkg::key_down,
		arcade_pkg::key_left, arcade_pkg::key_right, arcade_pkg::key_coin,
		arcade_pkg::key_start1, arcade_pkg::key_start2, arcade_pkg::key_fire1,
		arcade_pkg::key_fire2, arcade_pkg::key_fire3};

	arcade_shell #(.AUDIO_DIV(AUDIO_DIV), .DAC_WIDTH(DAC_WIDTH)) UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		#100000; // Whole run needs about 25 us
		$display("simulation stopped, run time limit reached");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ==================================================================
	// Model, compare and wait helpers
	// ==================================================================
	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	// Expected active-low word; straight is the status rotate bit
	function automatic logic [7:0] expected_buttons(input logic [7:0] j0, input logic [7:0] j1,
		input logic straight);
		logic       up, dn, lf, rt;
		logic [7:0] w;
		up = kbd_model[0] | j0[arcade_pkg::joy_up] | j1[arcade_pkg::joy_up];
		dn = kbd_model[1] | j0[arcade_pkg::joy_down] | j1[arcade_pkg::joy_down];
		lf = kbd_model[2] | j0[arcade_pkg::joy_left] | j1[arcade_pkg::joy_left];
		rt = kbd_model[3] | j0[arcade_pkg::joy_right] | j1[arcade_pkg::joy_right];
		w = '0;
		w[arcade_pkg::btn_up]     = straight ? up : lf;
		w[arcade_pkg::btn_down]   = straight ? dn : rt;
		w[arcade_pkg::btn_left]   = straight ? lf : dn;
		w[arcade_pkg::btn_right]  = straight ? rt : up;
		w[arcade_pkg::btn_start1] = kbd_model[5];
		w[arcade_pkg::btn_coin]   = kbd_model[4];
		w[arcade_pkg::btn_fire]   = kbd_model[7] | j0[arcade_pkg::joy_fire1]
			| j1[arcade_pkg::joy_fire1];
		w[arcade_pkg::btn_start2] = kbd_model[6];
		return ~w;
	endfunction

	function automatic logic [CW-1:0] expected_channel(input logic [2:0] c, input logic odd,
		input logic [1:0] mode);
		logic [CW-1:0] v;
		v = {c, c};
		if (odd && mode == arcade_pkg::scan_25) v = v - (v >> 2);
		if (odd && mode == arcade_pkg::scan_50) v = v >> 1;
		if (odd && mode == arcade_pkg::scan_75) v = v >> 2;
		return v;
	endfunction

	task automatic check_buttons(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("mismatch at %0t: %s, got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_pixel(input logic [CW-1:0] r, g, b, input logic hs, vs,
		input logic [CW-1:0] xr, xg, xb, input logic xhs, xvs);
		checks++;
		if ({r, g, b, hs, vs} !== {xr, xg, xb, xhs, xvs}) begin
			errors++;
			$display("mismatch at %0t: pixel, got %h %h %h hs %b vs %b expected %h %h %h hs %b vs %b",
				$time, r, g, b, hs, vs, xr, xg, xb, xhs, xvs);
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (core_reset !== 1'b0 && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (core_reset !== 1'b0) begin
			errors++;
			$display("core reset still active %0d cycles after reset release", n);
		end
	endtask

	task automatic wait_sound_pulse();
		int n;
		n = 0;
		@(posedge clk_sys);
		while (ce_1p79 !== 1'b1 && n < 2 * AUDIO_DIV) begin
			@(posedge clk_sys);
			n++;
		end
		if (ce_1p79 !== 1'b1) begin
			errors++;
			$display("no sound enable pulse within %0d cycles", n);
		end
	endtask

	task automatic report_test(input string name, input int mark);
		$display("test %s finished, %0d errors", name, errors - mark);
	endtask

	// ==================================================================
	// Test sequence
	// ==================================================================
	initial begin
		logic [31:0]   rnd;
		logic [CW-1:0] er, eg, eb;
		logic          ehs, evs, hs_prev, odd, have_exp;
		int            k, mark, n_star, n_pix, n_snd, n_high, n_high_r;
		seed = 8451;
		errors = 0;
		checks = 0;
		rst_n = 1'b1;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		status = '0;
		buttons = '0;
		core_r = '0;
		core_g = '0;
		core_b = '0;
		{core_hs, core_vs, core_hblank, core_vblank} = 4'b0000;
		core_audio = '0;
		foreach (kbd_model[n]) kbd_model[n] = 1'b0;
		#1 rst_n = 1'b0;
		repeat (3) @(negedge clk_sys);
		rst_n = 1'b1;
		wait_reset_release();

		// Clock enables, sampled at the rising edge
		mark = errors;
		wait_sound_pulse();
		n_star = 0;
		n_pix = 0;
		n_snd = 0;
		repeat (4 * AUDIO_DIV * 8) begin
			@(posedge clk_sys);
			n_star += ce_star;
			n_pix += ce_6p;
			n_snd += ce_1p79;
		end
		check_count(n_star, 2 * AUDIO_DIV * 8, "ce_star pulses");
		check_count(n_pix, AUDIO_DIV * 8, "ce_6p pulses");
		check_count(n_snd, 4 * 8, "ce_1p79 pulses");
		report_test("enables", mark);

		// Keyboard events, rotation off
		mark = errors;
		@(negedge clk_sys);
		status[arcade_pkg::st_rotate] = 1'b1;
		for (int i = 0; i < 60; i++) begin
			rnd = next_random();
			k = int'(rnd[11:4]) % 12;
			key_pressed = rnd[0];
			key_code = (k < 10) ? key_table[k] : ((k == 10) ? 8'h1C : 8'hF0); // Unknown keys
			key_strobe = 1'b1;
			if (k < 10) kbd_model[k] = rnd[0];
			@(negedge clk_sys);
			key_strobe = 1'b0;
			@(negedge clk_sys);
			check_buttons(core_buttons_n, expected_buttons(8'h00, 8'h00, 1'b1), "keyboard event");
		end
		report_test("keyboard", mark);

		mark = errors;
		for (int i = 0; i < 80; i++) begin
			rnd = next_random();
			joystick_0 = rnd[7:0];
			joystick_1 = rnd[15:8];
			status[arcade_pkg::st_rotate] = rnd[16];
			@(negedge clk_sys);
			check_buttons(core_buttons_n, expected_buttons(rnd[7:0], rnd[15:8], rnd[16]),
				"joystick merge");
		end
		report_test("joystick", mark);

		mark = errors;
		for (int i = 0; i < 40; i++) begin
			rnd = next_random();
			status[arcade_pkg::st_reset] = rnd[0];
			status[arcade_pkg::st_soft_reset] = rnd[1];
			buttons = {rnd[2], rnd[3]};
			@(negedge clk_sys);
			check_bit(core_reset, rnd[0] | rnd[1] | rnd[2], "core reset combine");
		end
		report_test("reset", mark);

		// Video, the model tracks line parity from core_hs edges
		mark = errors;
		status = '0;
		buttons = '0;
		hs_prev = 1'b0;
		odd = 1'b0;
		have_exp = 1'b0;
		for (int i = 0; i <= 200; i++) begin
			if (have_exp)
				check_pixel(vga_r, vga_g, vga_b, vga_hs, vga_vs, er, eg, eb, ehs, evs);
			rnd = next_random();
			core_r = rnd[2:0];
			core_g = rnd[5:3];
			core_b = rnd[8:6];
			core_hs = (rnd[12:10] == 3'd0); // Short sync pulses
			core_vs = rnd[13] & rnd[14];
			core_hblank = rnd[15] & rnd[16];
			core_vblank = rnd[17] & rnd[18] & rnd[19];
			status[arcade_pkg::st_scan_lo] = rnd[20];
			status[arcade_pkg::st_scan_hi] = rnd[21];
			er = (core_hblank | core_vblank) ? '0 : expected_channel(core_r, odd, rnd[21:20]);
			eg = (core_hblank | core_vblank) ? '0 : expected_channel(core_g, odd, rnd[21:20]);
			eb = (core_hblank | core_vblank) ? '0 : expected_channel(core_b, odd, rnd[21:20]);
			ehs = ~core_hs;
			evs = ~core_vs;
			if (core_hs && !hs_prev)
				odd = ~odd;
			hs_prev = core_hs;
			have_exp = 1'b1;
			@(negedge clk_sys);
		end
		report_test("video", mark);

		// DAC, one full accumulator period per sample
		mark = errors;
		for (int i = 0; i < 5; i++) begin
			rnd = next_random();
			core_audio = rnd[DAC_WIDTH-1:0];
			n_high = 0;
			n_high_r = 0;
			repeat (1 << DAC_WIDTH) begin
				@(negedge clk_sys);
				n_high += audio_l;
				n_high_r += audio_r;
			end
			check_count(n_high, int'(rnd[DAC_WIDTH-1:0]), "DAC high cycles on audio_l");
			check_count(n_high_r, int'(rnd[DAC_WIDTH-1:0]), "DAC high cycles on audio_r");
		end
		report_test("dac", mark);

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== compile.f ====
arcade_pkg.sv
kbd_buttons_if.sv
clock_enables.sv
key_decoder.sv
control_mapper.sv
video_output.sv
sigma_delta_dac.sv
arcade_shell.sv
arcade_shell_assertions.sv
tb_arcade_shell.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the arcade shell testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_arcade_shell \
	-f compile.f \
	-o sim_arcade_shell

./obj_dir/sim_arcade_shell > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "TEST RESULT: PASS" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
